// ==== design/station_pkg.sv ====
`default_nettype none

package station_pkg;

  // SRAM geometry of the board
  localparam int ADDR_W   = 20;
  localparam int DATA_W   = 16;
  localparam int BE_W     = 2;
  localparam int SAMPLE_W = 8;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [BE_W-1:0]     be_t;
  typedef logic [SAMPLE_W-1:0] sample_t;

  // cycles of clean clock before the system leaves reset
  localparam int RESET_STRETCH = 16;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_SETUP,
    ARB_STROBE
  } arb_state_e;

  typedef enum logic [2:0] {
    TST_IDLE,
    TST_FETCH,
    TST_WAIT_DATA,
    TST_SETTLE,
    TST_STORE
  } tester_state_e;

endpackage

`default_nettype wire

// ==== design/sram_bus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface sram_bus_if;
  import station_pkg::*;

  // request side, owned by the master
  addr_t address;
  be_t   byteenable;
  logic  read;
  logic  write;
  data_t writedata;

  // response side, owned by the arbiter
  logic  waitrequest;
  data_t readdata;
  logic  readdataready;

  modport master (
    output address, byteenable, read, write, writedata,
    input  waitrequest, readdata, readdataready
  );

  modport arbiter (
    input  address, byteenable, read, write, writedata,
    output waitrequest, readdata, readdataready
  );

endinterface

`default_nettype wire

// ==== design/reset_stretch.sv ====
`timescale 1ns/1ns
`default_nettype none

module reset_stretch (
  input  wire logic clock,
  input  wire logic rst_n,
  output logic      sys_rst_n
);
  import station_pkg::*;

  localparam int CNT_W = $clog2(RESET_STRETCH + 1);

  logic [1:0]       sync_q;
  logic [CNT_W-1:0] count_q;

  // assert at once, release through the synchronizer and then the counter
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      sync_q    <= 2'b00;
      count_q   <= '0;
      sys_rst_n <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
      if (sync_q[1] && !sys_rst_n) begin
        if (count_q == CNT_W'(RESET_STRETCH - 1)) begin
          sys_rst_n <= 1'b1;
        end else begin
          count_q <= count_q + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/sram_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module sram_arbiter (
  input  wire logic                clock,
  input  wire logic                rst_n,
  sram_bus_if.arbiter              tester,
  sram_bus_if.arbiter              adc,
  sram_bus_if.arbiter              host,
  output station_pkg::addr_t       sram_addr,
  output station_pkg::data_t       sram_dq_out,
  output logic                     sram_dq_oe,
  output logic                     sram_ce_n,
  output logic                     sram_oe_n,
  output logic                     sram_we_n,
  output station_pkg::be_t         sram_be_n,
  input  wire station_pkg::data_t  sram_dq_in
);
  import station_pkg::*;

  arb_state_e state_q;
  logic       run_q;
  logic [2:0] req;
  logic [2:0] gnt;
  logic [2:0] gnt_q;
  logic       is_wr_q;
  logic       rdv_q;
  data_t      rdata_q;

  // muxed request of the winner
  addr_t      sel_addr;
  be_t        sel_be;
  data_t      sel_data;
  logic       sel_wr;

  // bit 0 tester, bit 1 adc, bit 2 host
  assign req = {host.read | host.write, adc.read | adc.write, tester.read | tester.write};

  // fixed priority, one grant per idle cycle
  always_comb begin
    gnt = 3'b000;
    if (run_q && state_q == ARB_IDLE) begin
      if (req[0]) begin
        gnt = 3'b001;
      end else if (req[1]) begin
        gnt = 3'b010;
      end else if (req[2]) begin
        gnt = 3'b100;
      end
    end
  end

  always_comb begin
    if (gnt[0]) begin
      sel_addr = tester.address;
      sel_be   = tester.byteenable;
      sel_data = tester.writedata;
      sel_wr   = tester.write;
    end else if (gnt[1]) begin
      sel_addr = adc.address;
      sel_be   = adc.byteenable;
      sel_data = adc.writedata;
      sel_wr   = adc.write;
    end else begin
      sel_addr = host.address;
      sel_be   = host.byteenable;
      sel_data = host.writedata;
      sel_wr   = host.write;
    end
  end

  // losers and idle masters see waitrequest high
  assign tester.waitrequest = ~gnt[0];
  assign adc.waitrequest    = ~gnt[1];
  assign host.waitrequest   = ~gnt[2];

  assign tester.readdata = rdata_q;
  assign adc.readdata    = rdata_q;
  assign host.readdata   = rdata_q;

  // read return goes only to the master that owned the access
  assign tester.readdataready = rdv_q & gnt_q[0];
  assign adc.readdataready    = rdv_q & gnt_q[1];
  assign host.readdataready   = rdv_q & gnt_q[2];

  // setup then strobe, pins straight from flops
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= ARB_IDLE;
      run_q      <= 1'b0;
      gnt_q      <= 3'b000;
      rdv_q      <= 1'b0;
      sram_ce_n  <= 1'b1;
      sram_oe_n  <= 1'b1;
      sram_we_n  <= 1'b1;
      sram_dq_oe <= 1'b0;
    end else begin
      run_q <= 1'b1;
      rdv_q <= 1'b0;
      case (state_q)
        ARB_IDLE: begin
          if (|gnt) begin
            state_q    <= ARB_SETUP;
            gnt_q      <= gnt;
            sram_ce_n  <= 1'b0;
            sram_oe_n  <= sel_wr;
            sram_dq_oe <= sel_wr;
          end
        end
        ARB_SETUP: begin
          state_q   <= ARB_STROBE;
          sram_we_n <= ~is_wr_q;
        end
        ARB_STROBE: begin
          state_q    <= ARB_IDLE;
          sram_ce_n  <= 1'b1;
          sram_oe_n  <= 1'b1;
          sram_we_n  <= 1'b1;
          sram_dq_oe <= 1'b0;
          rdv_q      <= ~is_wr_q;
        end
        default: begin
          state_q <= ARB_IDLE;
        end
      endcase
    end
  end

  // address, data and byte lanes of the accepted request
  always_ff @(posedge clock) begin
    if (|gnt) begin
      sram_addr   <= sel_addr;
      sram_be_n   <= ~sel_be;
      sram_dq_out <= sel_data;
      is_wr_q     <= sel_wr;
    end
    // read data sampled at the end of strobe
    if (state_q == ARB_STROBE && !is_wr_q) begin
      rdata_q <= sram_dq_in;
    end
  end

endmodule

`default_nettype wire

// ==== design/adc_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module adc_capture #(
  parameter station_pkg::addr_t CAPTURE_BASE  = '0,
  parameter int                 CAPTURE_WORDS = 1
) (
  input  wire logic                 clock,
  input  wire logic                 rst_n,
  input  wire logic                 start,
  input  wire station_pkg::sample_t adc_data,
  output logic                      busy,
  output logic                      done,
  sram_bus_if.master                mem
);
  import station_pkg::*;

  logic    take_hi_q;
  logic    wr_q;
  addr_t   count_q;
  sample_t lo_q;
  sample_t hi_q;

  // write only, both bytes of each word
  assign mem.read       = 1'b0;
  assign mem.write      = wr_q;
  assign mem.byteenable = 2'b11;
  assign mem.address    = CAPTURE_BASE + count_q;
  assign mem.writedata  = {hi_q, lo_q};

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      done      <= 1'b0;
      take_hi_q <= 1'b0;
      wr_q      <= 1'b0;
      count_q   <= '0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        // start while busy falls through here and is dropped
        if (start) begin
          busy      <= 1'b1;
          take_hi_q <= 1'b0;
          count_q   <= '0;
        end
      end else if (wr_q) begin
        if (!mem.waitrequest) begin
          wr_q <= 1'b0;
          if (count_q == addr_t'(CAPTURE_WORDS - 1)) begin
            busy <= 1'b0;
            done <= 1'b1;
          end else begin
            count_q <= count_q + 1'b1;
          end
        end
      end else if (take_hi_q) begin
        take_hi_q <= 1'b0;
        wr_q      <= 1'b1;
      end else begin
        take_hi_q <= 1'b1;
      end
    end
  end

  // no sampling while a write is pending
  always_ff @(posedge clock) begin
    if (busy && !wr_q) begin
      if (take_hi_q) begin
        hi_q <= adc_data;
      end else begin
        lo_q <= adc_data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/pattern_tester.sv ====
`timescale 1ns/1ns
`default_nettype none

module pattern_tester #(
  parameter station_pkg::addr_t STIM_BASE     = '0,
  parameter station_pkg::addr_t RESULT_BASE   = '0,
  parameter int                 VECTOR_COUNT  = 1,
  parameter int                 SETTLE_CYCLES = 1
) (
  input  wire logic               clock,
  input  wire logic               rst_n,
  input  wire logic               start,
  input  wire station_pkg::data_t target_q,
  output logic                    busy,
  output logic                    done,
  output station_pkg::data_t      target_a,
  sram_bus_if.master              mem
);
  import station_pkg::*;

  localparam int SETTLE_W = (SETTLE_CYCLES > 1) ? $clog2(SETTLE_CYCLES) : 1;

  tester_state_e       state_q;
  addr_t               idx_q;
  logic [SETTLE_W-1:0] settle_q;
  logic                settled;
  data_t               result_q;

  assign settled = (settle_q == SETTLE_W'(SETTLE_CYCLES - 1));
  assign busy    = (state_q != TST_IDLE);

  // request held steady by the state while waitrequest is high
  assign mem.read       = (state_q == TST_FETCH);
  assign mem.write      = (state_q == TST_STORE);
  assign mem.byteenable = 2'b11;
  assign mem.writedata  = result_q;
  assign mem.address    = (state_q == TST_STORE) ? RESULT_BASE + idx_q : STIM_BASE + idx_q;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= TST_IDLE;
      idx_q    <= '0;
      settle_q <= '0;
      target_a <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state_q)
        TST_IDLE: begin
          if (start) begin
            idx_q   <= '0;
            state_q <= TST_FETCH;
          end
        end
        TST_FETCH: begin
          if (!mem.waitrequest) begin
            state_q <= TST_WAIT_DATA;
          end
        end
        TST_WAIT_DATA: begin
          // stimulus goes out to the target as soon as it returns
          if (mem.readdataready) begin
            target_a <= mem.readdata;
            settle_q <= '0;
            state_q  <= TST_SETTLE;
          end
        end
        TST_SETTLE: begin
          if (settled) begin
            state_q <= TST_STORE;
          end else begin
            settle_q <= settle_q + 1'b1;
          end
        end
        TST_STORE: begin
          if (!mem.waitrequest) begin
            if (idx_q == addr_t'(VECTOR_COUNT - 1)) begin
              done    <= 1'b1;
              state_q <= TST_IDLE;
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= TST_FETCH;
            end
          end
        end
        default: begin
          state_q <= TST_IDLE;
        end
      endcase
    end
  end

  // target response at the end of the settle time
  always_ff @(posedge clock) begin
    if (state_q == TST_SETTLE && settled) begin
      result_q <= target_q;
    end
  end

endmodule

`default_nettype wire

// ==== design/test_station.sv ====
`timescale 1ns/1ns
`default_nettype none

module test_station #(
  parameter station_pkg::addr_t CAPTURE_BASE  = 20'h00100,
  parameter int                 CAPTURE_WORDS = 8,
  parameter station_pkg::addr_t STIM_BASE     = 20'h00200,
  parameter station_pkg::addr_t RESULT_BASE   = 20'h00300,
  parameter int                 VECTOR_COUNT  = 12,
  parameter int                 SETTLE_CYCLES = 3
) (
  input  wire logic                 clock,
  input  wire logic                 rst_n,

  // host port
  input  wire station_pkg::addr_t   host_address,
  input  wire station_pkg::be_t     host_byteenable,
  input  wire logic                 host_read,
  input  wire logic                 host_write,
  input  wire station_pkg::data_t   host_writedata,
  output station_pkg::data_t        host_readdata,
  output logic                      host_readdataready,
  output logic                      host_waitrequest,

  // engine control
  input  wire logic                 adc_start,
  input  wire logic                 test_start,
  output logic                      adc_busy,
  output logic                      adc_done,
  output logic                      test_busy,
  output logic                      test_done,

  // ADC and target pins
  input  wire station_pkg::sample_t adc_data,
  input  wire station_pkg::data_t   target_q,
  output station_pkg::data_t        target_a,

  // SRAM, data bus split in and out
  input  wire station_pkg::data_t   sram_dq_in,
  output station_pkg::addr_t        sram_addr,
  output station_pkg::data_t        sram_dq_out,
  output logic                      sram_dq_oe,
  output logic                      sram_ce_n,
  output logic                      sram_oe_n,
  output logic                      sram_we_n,
  output station_pkg::be_t          sram_be_n
);

  logic sys_rst_n;

  sram_bus_if host_bus ();
  sram_bus_if adc_bus ();
  sram_bus_if tester_bus ();

  assign host_bus.address     = host_address;
  assign host_bus.byteenable  = host_byteenable;
  assign host_bus.read        = host_read;
  assign host_bus.write       = host_write;
  assign host_bus.writedata   = host_writedata;
  assign host_readdata        = host_bus.readdata;
  assign host_readdataready   = host_bus.readdataready;
  assign host_waitrequest     = host_bus.waitrequest;

  reset_stretch reset_stretch_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .sys_rst_n (sys_rst_n)
  );

  sram_arbiter sram_arbiter_i (
    .clock       (clock),
    .rst_n       (sys_rst_n),
    .tester      (tester_bus.arbiter),
    .adc         (adc_bus.arbiter),
    .host        (host_bus.arbiter),
    .sram_addr   (sram_addr),
    .sram_dq_out (sram_dq_out),
    .sram_dq_oe  (sram_dq_oe),
    .sram_ce_n   (sram_ce_n),
    .sram_oe_n   (sram_oe_n),
    .sram_we_n   (sram_we_n),
    .sram_be_n   (sram_be_n),
    .sram_dq_in  (sram_dq_in)
  );

  adc_capture #(
    .CAPTURE_BASE  (CAPTURE_BASE),
    .CAPTURE_WORDS (CAPTURE_WORDS)
  ) adc_capture_i (
    .clock    (clock),
    .rst_n    (sys_rst_n),
    .start    (adc_start),
    .adc_data (adc_data),
    .busy     (adc_busy),
    .done     (adc_done),
    .mem      (adc_bus.master)
  );

  pattern_tester #(
    .STIM_BASE     (STIM_BASE),
    .RESULT_BASE   (RESULT_BASE),
    .VECTOR_COUNT  (VECTOR_COUNT),
    .SETTLE_CYCLES (SETTLE_CYCLES)
  ) pattern_tester_i (
    .clock    (clock),
    .rst_n    (sys_rst_n),
    .start    (test_start),
    .target_q (target_q),
    .busy     (test_busy),
    .done     (test_done),
    .target_a (target_a),
    .mem      (tester_bus.master)
  );

endmodule

`default_nettype wire

// ==== test/sram_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module sram_model (
  input  wire logic               clock,
  input  wire station_pkg::addr_t addr,
  input  wire station_pkg::data_t wdata,
  input  wire logic               wdata_oe,
  output station_pkg::data_t      rdata,
  input  wire logic               ce_n,
  input  wire logic               oe_n,
  input  wire logic               we_n,
  input  wire station_pkg::be_t   be_n
);
  import station_pkg::*;

  localparam int WORDS = 1 << ADDR_W;

  data_t mem [WORDS];
  int    a;

  // power-up contents, every address bit takes part
  function automatic data_t initial_contents(input addr_t where);
    return where[15:0] ^ {4{where[19:16]}} ^ 16'h5a3c;
  endfunction

  initial begin
    for (a = 0; a < WORDS; a++) begin
      mem[a] = initial_contents(addr_t'(a));
    end
  end

  always @(posedge clock) begin
    if (!ce_n && !we_n && wdata_oe) begin
      if (!be_n[0]) begin
        mem[addr][7:0] <= wdata[7:0];
      end
      if (!be_n[1]) begin
        mem[addr][15:8] <= wdata[15:8];
      end
    end
  end

  // asynchronous read path
  assign rdata = (!ce_n && !oe_n) ? mem[addr] : '0;

endmodule

`default_nettype wire

// ==== test/tb_test_station.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_test_station #(
  parameter int SEED = 38
);
  import station_pkg::*;

  localparam int    CLK_PERIOD    = 8;
  localparam int    DRIVE_DELAY   = 1;
  localparam int    RESET_CYCLES  = 8;
  localparam addr_t CAPTURE_BASE  = 20'h00100;
  localparam int    CAPTURE_WORDS = 8;
  localparam addr_t STIM_BASE     = 20'h00200;
  localparam addr_t RESULT_BASE   = 20'h00300;
  localparam int    VECTOR_COUNT  = 12;
  localparam int    SETTLE_CYCLES = 3;
  localparam int    HOST_WRITES   = 64;
  localparam int    LOAD_OPS      = 24;
  localparam int    HOST_LIMIT    = 200;
  localparam int    ENGINE_LIMIT  = 2000;

  // rough cycle budget of the whole run
  localparam int HOST_OPS = 2 + 2 * HOST_WRITES + 3 * CAPTURE_WORDS + 4 * VECTOR_COUNT
                            + 2 * LOAD_OPS;
  localparam int EXPECTED_CYCLES = 16 + RESET_STRETCH + 6 * HOST_OPS
                                   + 2 * (4 * CAPTURE_WORDS + VECTOR_COUNT * (SETTLE_CYCLES + 10));

  logic    clock;
  logic    rst_n;
  addr_t   host_address;
  be_t     host_byteenable;
  logic    host_read;
  logic    host_write;
  data_t   host_writedata;
  data_t   host_readdata;
  logic    host_readdataready;
  logic    host_waitrequest;
  logic    adc_start;
  logic    test_start;
  logic    adc_busy;
  logic    adc_done;
  logic    test_busy;
  logic    test_done;
  sample_t adc_data;
  data_t   target_q;
  data_t   target_a;
  data_t   sram_dq_in;
  addr_t   sram_addr;
  data_t   sram_dq_out;
  logic    sram_dq_oe;
  logic    sram_ce_n;
  logic    sram_oe_n;
  logic    sram_we_n;
  be_t     sram_be_n;

  logic [15:0] lfsr_q;
  data_t       ref_mem [addr_t];
  data_t       stim [VECTOR_COUNT];
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          start_errors;

  test_station #(
    .CAPTURE_BASE  (CAPTURE_BASE),
    .CAPTURE_WORDS (CAPTURE_WORDS),
    .STIM_BASE     (STIM_BASE),
    .RESULT_BASE   (RESULT_BASE),
    .VECTOR_COUNT  (VECTOR_COUNT),
    .SETTLE_CYCLES (SETTLE_CYCLES)
  ) test_station_i (
    .clock (clock), .rst_n (rst_n),
    .host_address (host_address), .host_byteenable (host_byteenable),
    .host_read (host_read), .host_write (host_write), .host_writedata (host_writedata),
    .host_readdata (host_readdata), .host_readdataready (host_readdataready),
    .host_waitrequest (host_waitrequest),
    .adc_start (adc_start), .test_start (test_start),
    .adc_busy (adc_busy), .adc_done (adc_done), .test_busy (test_busy), .test_done (test_done),
    .adc_data (adc_data), .target_q (target_q), .target_a (target_a),
    .sram_dq_in (sram_dq_in), .sram_addr (sram_addr), .sram_dq_out (sram_dq_out),
    .sram_dq_oe (sram_dq_oe), .sram_ce_n (sram_ce_n), .sram_oe_n (sram_oe_n),
    .sram_we_n (sram_we_n), .sram_be_n (sram_be_n)
  );

  sram_model sram_model_i (
    .clock (clock), .addr (sram_addr), .wdata (sram_dq_out), .wdata_oe (sram_dq_oe),
    .rdata (sram_dq_in), .ce_n (sram_ce_n), .oe_n (sram_oe_n), .we_n (sram_we_n),
    .be_n (sram_be_n)
  );

  // target is a one-bit left shifter
  assign target_q = {target_a[14:0], 1'b0};

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // free-running sample count on the ADC pins
  initial begin
    adc_data = '0;
    forever begin
      @(posedge clock);
      #DRIVE_DELAY;
      adc_data = sample_t'(adc_data + 8'd1);
    end
  end

  initial begin
    #(20 * EXPECTED_CYCLES * CLK_PERIOD);
    $display("error at %0t: watchdog expired, run did not finish", $time);
    $display("Some tests failed");
    $finish;
  end

  // galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  function automatic data_t power_up_word(input addr_t a);
    return a[15:0] ^ {4{a[19:16]}} ^ 16'h5a3c;
  endfunction

  function automatic data_t model_word(input addr_t a);
    if (ref_mem.exists(a)) begin
      return ref_mem[a];
    end
    return power_up_word(a);
  endfunction

  function automatic void model_store(input addr_t a, input be_t be, input data_t d);
    data_t w;
    w = model_word(a);
    if (be[0]) begin
      w[7:0] = d[7:0];
    end
    if (be[1]) begin
      w[15:8] = d[15:8];
    end
    ref_mem[a] = w;
  endfunction

  task automatic compare_value(input string name, input data_t expected, input data_t actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic idle_levels();
    compare_value("control levels", data_t'(9'h1c0),
                  data_t'({sram_ce_n, sram_oe_n, sram_we_n, sram_dq_oe, adc_busy, adc_done,
                           test_busy, test_done, host_readdataready}));
  endtask

  // wait for the grant of the request on the pins and drop it
  task automatic await_accept(input addr_t a);
    int n;
    n = 0;
    do begin
      @(negedge clock);
      n++;
    end while (host_waitrequest && n < HOST_LIMIT);
    checks++;
    assert (!host_waitrequest) else begin
      errors++;
      $display("error at %0t: host request to %h was never accepted", $time, a);
    end
    @(posedge clock);
    #DRIVE_DELAY;
    host_read  = 1'b0;
    host_write = 1'b0;
  endtask

  task automatic write_host(input addr_t a, input be_t be, input data_t d);
    @(posedge clock);
    #DRIVE_DELAY;
    host_address    = a;
    host_byteenable = be;
    host_writedata  = d;
    host_write      = 1'b1;
    await_accept(a);
    model_store(a, be, d);
  endtask

  task automatic read_host(input addr_t a, output data_t d);
    int n;
    @(posedge clock);
    #DRIVE_DELAY;
    host_address    = a;
    host_byteenable = 2'b11;
    host_read       = 1'b1;
    await_accept(a);
    n = 0;
    do begin
      @(negedge clock);
      n++;
    end while (!host_readdataready && n < HOST_LIMIT);
    checks++;
    assert (host_readdataready) else begin
      errors++;
      $display("error at %0t: read of %h returned no data", $time, a);
    end
    d = host_readdata;
  endtask

  task automatic pulse_starts(input logic adc, input logic tst);
    @(posedge clock);
    #DRIVE_DELAY;
    adc_start  = adc;
    test_start = tst;
    @(posedge clock);
    #DRIVE_DELAY;
    adc_start  = 1'b0;
    test_start = 1'b0;
  endtask

  // busy must hold until the done pulse
  task automatic await_adc();
    int n;
    n = 0;
    @(negedge clock);
    while (!adc_done && n < ENGINE_LIMIT) begin
      checks++;
      assert (adc_busy) else begin
        errors++;
        $display("error at %0t: adc_busy dropped before adc_done", $time);
      end
      @(negedge clock);
      n++;
    end
    checks++;
    assert (adc_done) else begin
      errors++;
      $display("error at %0t: adc_done never arrived", $time);
    end
  endtask

  task automatic await_test();
    int n;
    n = 0;
    @(negedge clock);
    while (!test_done && n < ENGINE_LIMIT) begin
      checks++;
      assert (test_busy) else begin
        errors++;
        $display("error at %0t: test_busy dropped before test_done", $time);
      end
      @(negedge clock);
      n++;
    end
    checks++;
    assert (test_done) else begin
      errors++;
      $display("error at %0t: test_done never arrived", $time);
    end
  endtask

  task automatic check_capture();
    data_t   got;
    sample_t prev_lo;
    sample_t step;
    int      i;
    prev_lo = '0;
    for (i = 0; i < CAPTURE_WORDS; i++) begin
      read_host(addr_t'(CAPTURE_BASE + i), got);
      compare_value("capture high byte", data_t'(sample_t'(got[7:0] + 8'd1)),
                    data_t'(got[15:8]));
      step = sample_t'(got[7:0] - prev_lo);
      if (i > 0) begin
        checks++;
        assert (step != 0 && step < 8'd128) else begin
          errors++;
          $display("error at %0t: capture word %0d low byte did not increase", $time, i);
        end
      end
      prev_lo = got[7:0];
    end
  endtask

  task automatic load_stimulus();
    int i;
    for (i = 0; i < VECTOR_COUNT; i++) begin
      stim[i] = data_t'(random_bits(16));
      write_host(addr_t'(STIM_BASE + i), 2'b11, stim[i]);
    end
  endtask

  task automatic verify_results();
    data_t got;
    data_t exp;
    int    i;
    for (i = 0; i < VECTOR_COUNT; i++) begin
      exp = data_t'(stim[i] << 1);
      model_store(addr_t'(RESULT_BASE + i), 2'b11, exp);
      read_host(addr_t'(RESULT_BASE + i), got);
      compare_value("host_readdata", exp, got);
    end
  endtask

  task automatic reset_behavior();
    addr_t a;
    data_t d;
    data_t got;
    int    n;
    a = addr_t'(random_bits(20));
    d = data_t'(random_bits(16));
    // write pending through the whole reset
    host_address    = a;
    host_byteenable = 2'b11;
    host_writedata  = d;
    host_write      = 1'b1;
    repeat (RESET_CYCLES) begin
      @(negedge clock);
      idle_levels();
    end
    @(posedge clock);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    n = 0;
    do begin
      @(negedge clock);
      idle_levels();
      n++;
    end while (host_waitrequest && n < HOST_LIMIT);
    checks++;
    assert (!host_waitrequest && n > RESET_STRETCH) else begin
      errors++;
      $display("error at %0t: first grant %0d cycles after reset release", $time, n);
    end
    @(posedge clock);
    #DRIVE_DELAY;
    host_write = 1'b0;
    model_store(a, 2'b11, d);
    read_host(a, got);
    compare_value("host_readdata", model_word(a), got);
  endtask

  task automatic host_roundtrip();
    addr_t addrs [HOST_WRITES];
    data_t got;
    int    i;
    for (i = 0; i < HOST_WRITES; i++) begin
      addrs[i] = addr_t'(random_bits(20));
      write_host(addrs[i], be_t'(random_bits(2)), data_t'(random_bits(16)));
    end
    for (i = 0; i < HOST_WRITES; i++) begin
      read_host(addrs[i], got);
      compare_value("host_readdata", model_word(addrs[i]), got);
    end
  endtask

  task automatic capture_block();
    pulse_starts(1'b1, 1'b0);
    await_adc();
    check_capture();
  endtask

  task automatic pattern_run();
    load_stimulus();
    pulse_starts(1'b0, 1'b1);
    await_test();
    verify_results();
  endtask

  task automatic loaded_arbitration();
    addr_t addrs [LOAD_OPS];
    data_t got;
    int    i;
    // clear the capture block so a lost ADC write shows up
    for (i = 0; i < CAPTURE_WORDS; i++) begin
      write_host(addr_t'(CAPTURE_BASE + i), 2'b11, '0);
    end
    load_stimulus();
    pulse_starts(1'b1, 1'b1);
    fork
      begin
        // host traffic kept well above the engine regions
        for (i = 0; i < LOAD_OPS; i++) begin
          addrs[i] = addr_t'(32'h10000 | random_bits(16));
          write_host(addrs[i], be_t'(random_bits(2)), data_t'(random_bits(16)));
        end
        for (i = 0; i < LOAD_OPS; i++) begin
          read_host(addrs[i], got);
          compare_value("host_readdata", model_word(addrs[i]), got);
        end
      end
      await_adc();
      await_test();
    join
    verify_results();
    check_capture();
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors > errs_before) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  initial begin
    lfsr_q          = 16'(SEED);
    rst_n           = 1'b0;
    host_address    = '0;
    host_byteenable = '0;
    host_read       = 1'b0;
    host_write      = 1'b0;
    host_writedata  = '0;
    adc_start       = 1'b0;
    test_start      = 1'b0;
    errors          = 0;
    checks          = 0;
    tests_run       = 0;
    tests_failed    = 0;

    start_errors = errors;
    reset_behavior();
    finish_test("reset levels", start_errors);
    start_errors = errors;
    host_roundtrip();
    finish_test("host write and read", start_errors);
    start_errors = errors;
    capture_block();
    finish_test("adc capture", start_errors);
    start_errors = errors;
    pattern_run();
    finish_test("pattern test", start_errors);
    start_errors = errors;
    loaded_arbitration();
    finish_test("arbitration under load", start_errors);

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
             checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
design/station_pkg.sv
design/sram_bus_if.sv
design/reset_stretch.sv
design/sram_arbiter.sv
design/adc_capture.sv
design/pattern_tester.sv
design/test_station.sv
test/sram_model.sv
test/tb_test_station.sv

// ==== Makefile ====
# Verilator flow for the memory test station

VERILATOR ?= verilator
TOP       ?= tb_test_station
SEED      ?= 38
LOG       ?= sim.log
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT := All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-f $(FLIST) --Mdir $(OBJ_DIR) -o sim_$(TOP)
	./$(OBJ_DIR)/sim_$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
